//--- src/had_consts.svh
// Debug access unit constants
// HACR field positions, reset value, bank and index numbers,
// ID value, trace FIFO depth and Wishbone word addresses
`ifndef HAD_CONSTS_SVH
`define HAD_CONSTS_SVH

// HACR reset value selects the ID register for read
`define HAD_HACR_RESET      16'h8200

// HACR field positions
`define HAD_HACR_RW         15
`define HAD_HACR_GO         14
`define HAD_HACR_EX         13
`define HAD_HACR_IDX_MSB    12
`define HAD_HACR_IDX_LSB    8
`define HAD_HACR_BANK_MSB   6
`define HAD_HACR_BANK_LSB   4
`define HAD_HACR_CORE_MSB   1
`define HAD_HACR_CORE_LSB   0

// Register banks
`define HAD_BANK0           3'd0
`define HAD_BANK1           3'd1
`define HAD_BANK2           3'd2

// Bank 0 register indices
`define HAD_IDX_ID          5'd2
`define HAD_IDX_PCFIFO      5'd6
`define HAD_IDX_BYPASS      5'd12
`define HAD_IDX_HCR         5'd13
`define HAD_IDX_HSR         5'd14
`define HAD_IDX_WBBR        5'd17
`define HAD_IDX_PC          5'd19
`define HAD_IDX_IR          5'd20
`define HAD_IDX_CSR         5'd21
`define HAD_IDX_DADDR       5'd24
`define HAD_IDX_DDATA       5'd25

`define HAD_ID_VALUE        64'h4841_4430_0001_0a15
`define HAD_PCFIFO_DEPTH    8

// Wishbone word addresses
`define HAD_WB_ADR_HACR     2'd0
`define HAD_WB_ADR_DR_LO    2'd1
`define HAD_WB_ADR_DR_HI    2'd2
`define HAD_WB_ADR_STATUS   2'd3

`endif

//--- src/had_pkg.sv
// Debug access unit types
// Register select shared by the IR decode and the register file,
// and the handshake states of the Wishbone front end
package had_pkg;

  // Debug register selected by HACR
  typedef enum logic [4:0] {
    REG_NONE,
    REG_ID,
    REG_HCR,
    REG_HSR,
    REG_WBBR,
    REG_PC,
    REG_IR,
    REG_CSR,
    REG_DADDR,
    REG_DDATA,
    REG_PCFIFO
  } reg_sel_e;

  // Front end transfer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_ACK,
    ST_WAIT_DROP,
    ST_RESP
  } front_state_e;

endpackage

//--- src/sync_level2pulse.sv
// Level to pulse synchronizer
// Two flops resynchronize a request level, a third keeps the previous
// synced value. The rising edge gives a one-cycle pulse and the synced
// level goes back to the sender as acknowledge
`timescale 1ns/1ps

module sync_level2pulse (
  input  logic cpuclk,
  input  logic cpurst_b,
  input  logic sync_in,
  output logic sync_out,
  output logic sync_ack
);

  logic sync_ff1;
  logic sync_ff2;
  logic sync_ff3;

  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      sync_ff1 <= 1'b0;
      sync_ff2 <= 1'b0;
      sync_ff3 <= 1'b0;
    end else begin
      sync_ff1 <= sync_in;
      sync_ff2 <= sync_ff1;
      sync_ff3 <= sync_ff2;
    end
  end

  // Rising edge of the synced level
  assign sync_out = sync_ff2 & ~sync_ff3;
  assign sync_ack = sync_ff2;

  // Sender holds the level until the synced copy comes back
  a_hold_until_ack: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    $fell(sync_in) |-> sync_ack);

endmodule

//--- src/had_wb_front.sv
// Wishbone front end of the debug access unit
// Stages the low data word, raises the IR or DR update level for HACR
// and DR_HI writes and completes the synchronizer handshake before ack.
// Reads return HACR, the two data halves or the FIFO status
`timescale 1ns/1ps
`include "had_consts.svh"

module had_wb_front (
  input  logic        cpuclk,
  input  logic        cpurst_b,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic        update_ir,
  output logic        update_dr,
  input  logic        ir_ack,
  input  logic        dr_ack,
  output logic [63:0] wdata,
  input  logic [15:0] hacr,
  input  logic [63:0] rdata,
  input  logic        fifo_empty,
  input  logic        fifo_full
);

  had_pkg::front_state_e state;
  logic                  op_dr;
  logic [31:0]           dr_lo;
  logic                  wr_hacr;
  logic                  wr_dr_hi;
  logic                  sel_ack;

  assign wr_hacr  = wb_we && (wb_adr == `HAD_WB_ADR_HACR);
  assign wr_dr_hi = wb_we && (wb_adr == `HAD_WB_ADR_DR_HI);
  // Acknowledge of the synchronizer in use
  assign sel_ack  = op_dr ? dr_ack : ir_ack;

  //============================================================
  // Transfer state machine
  //============================================================
  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      state     <= had_pkg::ST_IDLE;
      op_dr     <= 1'b0;
      update_ir <= 1'b0;
      update_dr <= 1'b0;
    end else begin
      case (state)
        had_pkg::ST_IDLE: begin
          if (wb_cyc && wb_stb) begin
            if (wr_hacr || wr_dr_hi) begin
              op_dr     <= wr_dr_hi;
              update_ir <= wr_hacr;
              update_dr <= wr_dr_hi;
              state     <= had_pkg::ST_WAIT_ACK;
            end else begin
              state <= had_pkg::ST_RESP;
            end
          end
        end
        had_pkg::ST_WAIT_ACK: begin
          // Far side has seen the level, release it
          if (sel_ack) begin
            update_ir <= 1'b0;
            update_dr <= 1'b0;
            state     <= had_pkg::ST_WAIT_DROP;
          end
        end
        had_pkg::ST_WAIT_DROP: begin
          if (!sel_ack) begin
            state <= had_pkg::ST_RESP;
          end
        end
        default: begin
          state <= had_pkg::ST_IDLE;
        end
      endcase
    end
  end

  assign wb_ack = (state == had_pkg::ST_RESP);

  //============================================================
  // Write data staging
  //============================================================
  always_ff @(posedge cpuclk) begin
    if ((state == had_pkg::ST_IDLE) && wb_cyc && wb_stb) begin
      if (wb_we && (wb_adr == `HAD_WB_ADR_DR_LO)) begin
        dr_lo <= wb_dat_w;
      end
      // Held steady for the whole handshake
      if (wr_hacr) begin
        wdata <= {32'h0, wb_dat_w};
      end else if (wr_dr_hi) begin
        wdata <= {wb_dat_w, dr_lo};
      end
    end
  end

  // Read mux, master holds the address until ack
  always_comb begin
    case (wb_adr)
      `HAD_WB_ADR_HACR:  wb_dat_r = {16'h0, hacr};
      `HAD_WB_ADR_DR_LO: wb_dat_r = rdata[31:0];
      `HAD_WB_ADR_DR_HI: wb_dat_r = rdata[63:32];
      default:           wb_dat_r = {30'h0, fifo_full, fifo_empty};
    endcase
  end

  a_ack_in_cycle: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    wb_ack |-> (wb_cyc && wb_stb));

endmodule

//--- src/had_private_ir.sv
// Private instruction register of one core
// Holds HACR, matches its core field against this core and decodes
// bank and index into a register select. Produces the trace FIFO pop,
// the DR update enable, go/exit requests and a clock enable hint
`timescale 1ns/1ps
`include "had_consts.svh"

module had_private_ir (
  input  logic                 cpuclk,
  input  logic                 cpurst_b,
  input  logic [1:0]           core_id,
  input  logic                 dbg_disable,
  input  logic                 update_ir_pulse,
  input  logic                 update_dr_pulse,
  input  logic                 update_ir,
  input  logic                 update_dr,
  input  logic [63:0]          wdata,
  output logic [15:0]          hacr,
  output had_pkg::reg_sel_e    reg_sel,
  output logic                 dr_update_en,
  output logic                 pcfifo_pop,
  output logic                 core_go,
  output logic                 core_ex,
  output logic                 exit_dbg_reg,
  output logic                 had_clk_en
);

  logic       ir_upd;
  logic       dr_upd;
  logic       ir_upd_ff1;
  logic       dr_upd_ff1;
  logic       hacr_rw;
  logic       core_sel;
  logic       bypass_sel;
  logic [4:0] hacr_index;
  logic [2:0] hacr_bank;

  // Updates are ignored while debug is disabled
  assign ir_upd = update_ir_pulse && !dbg_disable;
  assign dr_upd = update_dr_pulse && !dbg_disable;

  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      ir_upd_ff1 <= 1'b0;
      dr_upd_ff1 <= 1'b0;
    end else begin
      ir_upd_ff1 <= ir_upd;
      dr_upd_ff1 <= dr_upd;
    end
  end

  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      hacr <= `HAD_HACR_RESET;
    end else if (ir_upd) begin
      hacr <= wdata[15:0];
    end
  end

  //============================================================
  // HACR decode
  //============================================================
  assign hacr_rw    = hacr[`HAD_HACR_RW];
  assign hacr_index = hacr[`HAD_HACR_IDX_MSB:`HAD_HACR_IDX_LSB];
  assign hacr_bank  = hacr[`HAD_HACR_BANK_MSB:`HAD_HACR_BANK_LSB];
  assign core_sel   = (hacr[`HAD_HACR_CORE_MSB:`HAD_HACR_CORE_LSB] == core_id);

  always_comb begin
    reg_sel = had_pkg::REG_NONE;
    if (hacr_bank == `HAD_BANK0) begin
      case (hacr_index)
        `HAD_IDX_ID:     reg_sel = had_pkg::REG_ID;
        `HAD_IDX_PCFIFO: reg_sel = had_pkg::REG_PCFIFO;
        `HAD_IDX_HCR:    reg_sel = had_pkg::REG_HCR;
        `HAD_IDX_HSR:    reg_sel = had_pkg::REG_HSR;
        `HAD_IDX_WBBR:   reg_sel = had_pkg::REG_WBBR;
        `HAD_IDX_PC:     reg_sel = had_pkg::REG_PC;
        `HAD_IDX_IR:     reg_sel = had_pkg::REG_IR;
        `HAD_IDX_CSR:    reg_sel = had_pkg::REG_CSR;
        `HAD_IDX_DADDR:  reg_sel = had_pkg::REG_DADDR;
        `HAD_IDX_DDATA:  reg_sel = had_pkg::REG_DDATA;
        default:         reg_sel = had_pkg::REG_NONE;
      endcase
    end
  end

  // Bypass has no storage but still counts as an exit register
  assign bypass_sel = (hacr_bank == `HAD_BANK0) && (hacr_index == `HAD_IDX_BYPASS);

  //============================================================
  // Core-qualified requests
  //============================================================
  assign core_go = hacr[`HAD_HACR_GO] && core_sel;
  assign core_ex = hacr[`HAD_HACR_EX] && core_sel;

  assign pcfifo_pop   = ir_upd_ff1 && hacr_rw && (reg_sel == had_pkg::REG_PCFIFO) && core_sel;
  assign dr_update_en = dr_upd_ff1 && !hacr_rw && core_sel;

  assign exit_dbg_reg = (reg_sel == had_pkg::REG_WBBR) ||
                        (reg_sel == had_pkg::REG_PC)   ||
                        (reg_sel == had_pkg::REG_IR)   ||
                        (reg_sel == had_pkg::REG_CSR)  ||
                        bypass_sel;

  // Keep clocks running while any update is in flight
  assign had_clk_en = update_ir || update_dr;

  // IR and DR updates never cross together
  a_single_update: assert property (@(posedge cpuclk) disable iff (!cpurst_b)
    !(update_ir_pulse && update_dr_pulse));

endmodule

//--- src/had_regfile.sv
// Debug register file
// Holds the writable debug registers, written from the DR data on the
// update enable, and returns the selected one. A latch keeps the word
// last popped from the trace FIFO
`timescale 1ns/1ps
`include "had_consts.svh"

module had_regfile (
  input  logic              cpuclk,
  input  logic              cpurst_b,
  input  had_pkg::reg_sel_e reg_sel,
  input  logic              dr_update_en,
  input  logic [63:0]       wdata,
  input  logic [63:0]       pop_data,
  input  logic              pcfifo_pop,
  output logic [63:0]       rdata
);

  logic [63:0] hcr;
  logic [63:0] wbbr;
  logic [63:0] pc;
  logic [63:0] ir;
  logic [63:0] csr;
  logic [63:0] daddr;
  logic [63:0] ddata;
  logic [63:0] pop_latch;

  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      hcr   <= 64'h0;
      wbbr  <= 64'h0;
      pc    <= 64'h0;
      ir    <= 64'h0;
      csr   <= 64'h0;
      daddr <= 64'h0;
      ddata <= 64'h0;
    end else if (dr_update_en) begin
      // ID and HSR are read only
      case (reg_sel)
        had_pkg::REG_HCR:   hcr   <= wdata;
        had_pkg::REG_WBBR:  wbbr  <= wdata;
        had_pkg::REG_PC:    pc    <= wdata;
        had_pkg::REG_IR:    ir    <= wdata;
        had_pkg::REG_CSR:   csr   <= wdata;
        had_pkg::REG_DADDR: daddr <= wdata;
        had_pkg::REG_DDATA: ddata <= wdata;
        default: ;
      endcase
    end
  end

  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      pop_latch <= 64'h0;
    end else if (pcfifo_pop) begin
      pop_latch <= pop_data;
    end
  end

  always_comb begin
    case (reg_sel)
      had_pkg::REG_ID:     rdata = `HAD_ID_VALUE;
      had_pkg::REG_HCR:    rdata = hcr;
      had_pkg::REG_WBBR:   rdata = wbbr;
      had_pkg::REG_PC:     rdata = pc;
      had_pkg::REG_IR:     rdata = ir;
      had_pkg::REG_CSR:    rdata = csr;
      had_pkg::REG_DADDR:  rdata = daddr;
      had_pkg::REG_DDATA:  rdata = ddata;
      had_pkg::REG_PCFIFO: rdata = pop_latch;
      // HSR has no status sources yet
      default:             rdata = 64'h0;
    endcase
  end

endmodule

//--- src/had_pcfifo.sv
// Program counter trace FIFO
// Circular buffer filled from the core trace port and popped by
// HACR read commands. Pushes into a full buffer are dropped
`timescale 1ns/1ps
`include "had_consts.svh"

module had_pcfifo (
  input  logic        cpuclk,
  input  logic        cpurst_b,
  input  logic        push,
  input  logic [63:0] push_data,
  input  logic        pop,
  output logic [63:0] pop_data,
  output logic        empty,
  output logic        full
);

  localparam int PTR_W = $clog2(`HAD_PCFIFO_DEPTH);

  logic [63:0]      mem [`HAD_PCFIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  assign empty   = (count == '0);
  assign full    = (count == (PTR_W+1)'(`HAD_PCFIFO_DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge cpuclk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
    end
  end

  always_ff @(posedge cpuclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Empty buffer pops as zero
  assign pop_data = empty ? 64'h0 : mem[rd_ptr];

endmodule

//--- src/had_top.sv
// Host debug register access unit, top level
// Wishbone front end, IR and DR update synchronizers, private IR,
// debug register file and PC trace FIFO for one core
`timescale 1ns/1ps

module had_top (
  input  logic        cpuclk,
  input  logic        cpurst_b,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [1:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  input  logic [1:0]  core_id,
  input  logic        dbg_disable,
  input  logic        trace_valid,
  input  logic [63:0] trace_pc,
  output logic        core_go,
  output logic        core_ex,
  output logic        exit_dbg_reg,
  output logic        had_clk_en
);

  logic              update_ir;
  logic              update_dr;
  logic              ir_ack;
  logic              dr_ack;
  logic              update_ir_pulse;
  logic              update_dr_pulse;
  logic [63:0]       wdata;
  logic [15:0]       hacr;
  logic [63:0]       rdata;
  logic              fifo_empty;
  logic              fifo_full;
  had_pkg::reg_sel_e reg_sel;
  logic              dr_update_en;
  logic              pcfifo_pop;
  logic [63:0]       pop_data;

  had_wb_front x_had_wb_front (
    .cpuclk     (cpuclk),
    .cpurst_b   (cpurst_b),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .update_ir  (update_ir),
    .update_dr  (update_dr),
    .ir_ack     (ir_ack),
    .dr_ack     (dr_ack),
    .wdata      (wdata),
    .hacr       (hacr),
    .rdata      (rdata),
    .fifo_empty (fifo_empty),
    .fifo_full  (fifo_full)
  );

  //============================================================
  // Update synchronizers
  //============================================================
  sync_level2pulse x_sync_ir (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b),
    .sync_in  (update_ir),
    .sync_out (update_ir_pulse),
    .sync_ack (ir_ack)
  );

  sync_level2pulse x_sync_dr (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b),
    .sync_in  (update_dr),
    .sync_out (update_dr_pulse),
    .sync_ack (dr_ack)
  );

  had_private_ir x_had_private_ir (
    .cpuclk          (cpuclk),
    .cpurst_b        (cpurst_b),
    .core_id         (core_id),
    .dbg_disable     (dbg_disable),
    .update_ir_pulse (update_ir_pulse),
    .update_dr_pulse (update_dr_pulse),
    .update_ir       (update_ir),
    .update_dr       (update_dr),
    .wdata           (wdata),
    .hacr            (hacr),
    .reg_sel         (reg_sel),
    .dr_update_en    (dr_update_en),
    .pcfifo_pop      (pcfifo_pop),
    .core_go         (core_go),
    .core_ex         (core_ex),
    .exit_dbg_reg    (exit_dbg_reg),
    .had_clk_en      (had_clk_en)
  );

  had_regfile x_had_regfile (
    .cpuclk       (cpuclk),
    .cpurst_b     (cpurst_b),
    .reg_sel      (reg_sel),
    .dr_update_en (dr_update_en),
    .wdata        (wdata),
    .pop_data     (pop_data),
    .pcfifo_pop   (pcfifo_pop),
    .rdata        (rdata)
  );

  had_pcfifo x_had_pcfifo (
    .cpuclk    (cpuclk),
    .cpurst_b  (cpurst_b),
    .push      (trace_valid),
    .push_data (trace_pc),
    .pop       (pcfifo_pop),
    .pop_data  (pop_data),
    .empty     (fifo_empty),
    .full      (fifo_full)
  );

endmodule

//--- testbench/tb_clkgen.sv
// Testbench clock and reset generator
// 100 ns clock, active low reset held for the first 5 cycles
`timescale 1ns/1ps

module tb_clkgen (
  output logic cpuclk,
  output logic cpurst_b
);

  localparam int PERIOD = 100;

  initial begin
    cpuclk = 1'b0;
    forever #(PERIOD / 2) cpuclk = ~cpuclk;
  end

  // Release away from the rising edge
  initial begin
    cpurst_b = 1'b0;
    repeat (5) @(posedge cpuclk);
    @(negedge cpuclk);
    cpurst_b = 1'b1;
  end

endmodule

//--- testbench/tb_had_top.sv
// Testbench for the host debug register access unit
// Drives the Wishbone and trace ports, keeps a model of HACR, the debug
// registers and the trace FIFO, and compares reads and core requests
`timescale 1ns/1ps
`include "had_consts.svh"

module tb_had_top;

  localparam int CLK_PERIOD = 100;
  // 400 bus transfers of at most 10 cycles each
  localparam int TIMEOUT_NS = 400 * 10 * CLK_PERIOD;

  logic        cpuclk;
  logic        cpurst_b;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [1:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic [1:0]  core_id;
  logic        dbg_disable;
  logic        trace_valid;
  logic [63:0] trace_pc;
  logic        core_go;
  logic        core_ex;
  logic        exit_dbg_reg;
  logic        had_clk_en;

  int          errors;
  int          checks;
  logic [31:0] lfsr;
  // Reference model state
  logic [15:0] m_hacr;
  logic [63:0] m_regs [32];
  logic [63:0] m_fifo [$];
  logic [4:0]  wr_idx [7] = '{`HAD_IDX_HCR, `HAD_IDX_WBBR, `HAD_IDX_PC, `HAD_IDX_IR,
                              `HAD_IDX_CSR, `HAD_IDX_DADDR, `HAD_IDX_DDATA};

  tb_clkgen x_tb_clkgen (
    .cpuclk   (cpuclk),
    .cpurst_b (cpurst_b)
  );

  had_top had_top_inst (
    .cpuclk       (cpuclk),
    .cpurst_b     (cpurst_b),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .core_id      (core_id),
    .dbg_disable  (dbg_disable),
    .trace_valid  (trace_valid),
    .trace_pc     (trace_pc),
    .core_go      (core_go),
    .core_ex      (core_ex),
    .exit_dbg_reg (exit_dbg_reg),
    .had_clk_en   (had_clk_en)
  );

  //============================================================
  // Random data and reference model
  //============================================================
  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = 32'h0;
    for (i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [15:0] make_hacr(input logic rw, input logic go, input logic ex,
                                             input logic [2:0] bank, input logic [4:0] idx,
                                             input logic [1:0] core);
    logic [15:0] h;
    h = 16'h0;
    h[`HAD_HACR_RW] = rw;
    h[`HAD_HACR_GO] = go;
    h[`HAD_HACR_EX] = ex;
    h[`HAD_HACR_IDX_MSB:`HAD_HACR_IDX_LSB] = idx;
    h[`HAD_HACR_BANK_MSB:`HAD_HACR_BANK_LSB] = bank;
    h[`HAD_HACR_CORE_MSB:`HAD_HACR_CORE_LSB] = core;
    return h;
  endfunction

  function automatic had_pkg::reg_sel_e ref_decode(input logic [15:0] h);
    had_pkg::reg_sel_e sel;
    sel = had_pkg::REG_NONE;
    if (h[`HAD_HACR_BANK_MSB:`HAD_HACR_BANK_LSB] == `HAD_BANK0) begin
      case (h[`HAD_HACR_IDX_MSB:`HAD_HACR_IDX_LSB])
        `HAD_IDX_ID:     sel = had_pkg::REG_ID;
        `HAD_IDX_PCFIFO: sel = had_pkg::REG_PCFIFO;
        `HAD_IDX_HCR:    sel = had_pkg::REG_HCR;
        `HAD_IDX_HSR:    sel = had_pkg::REG_HSR;
        `HAD_IDX_WBBR:   sel = had_pkg::REG_WBBR;
        `HAD_IDX_PC:     sel = had_pkg::REG_PC;
        `HAD_IDX_IR:     sel = had_pkg::REG_IR;
        `HAD_IDX_CSR:    sel = had_pkg::REG_CSR;
        `HAD_IDX_DADDR:  sel = had_pkg::REG_DADDR;
        `HAD_IDX_DDATA:  sel = had_pkg::REG_DDATA;
        default:         sel = had_pkg::REG_NONE;
      endcase
    end
    return sel;
  endfunction

  function automatic logic core_match(input logic [15:0] h);
    return h[`HAD_HACR_CORE_MSB:`HAD_HACR_CORE_LSB] == core_id;
  endfunction

  // Exit group is WBBR, PC, IR, CSR and bank 0 bypass
  function automatic logic exit_expected(input logic [15:0] h);
    had_pkg::reg_sel_e sel;
    logic              bypass;
    sel = ref_decode(h);
    bypass = (h[`HAD_HACR_BANK_MSB:`HAD_HACR_BANK_LSB] == `HAD_BANK0) &&
             (h[`HAD_HACR_IDX_MSB:`HAD_HACR_IDX_LSB] == `HAD_IDX_BYPASS);
    return (sel == had_pkg::REG_WBBR) || (sel == had_pkg::REG_PC) ||
           (sel == had_pkg::REG_IR) || (sel == had_pkg::REG_CSR) || bypass;
  endfunction

  //============================================================
  // Compare tasks
  //============================================================
  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_hacr(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_sel(input had_pkg::reg_sel_e got, input had_pkg::reg_sel_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: %0t reg_sel got %s expected %s", $time, got.name(), exp.name());
    end
  endtask

  //============================================================
  // Bus and trace port tasks
  //============================================================
  // Waits for ack, frees the bus and returns one falling edge later
  task automatic finish_xfer(input logic upd_exp, output logic [31:0] dat);
    logic clk_seen;
    clk_seen = 1'b0;
    @(negedge cpuclk);
    while (wb_ack !== 1'b1) begin
      clk_seen = clk_seen | had_clk_en;
      @(negedge cpuclk);
    end
    dat = wb_dat_r;
    // Only IR and DR_HI writes raise an update level
    check_bit("had_clk_en", clk_seen, upd_exp);
    @(posedge cpuclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    // Ack lasts a single cycle
    @(negedge cpuclk);
    check_bit("wb_ack", wb_ack, 1'b0);
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    @(posedge cpuclk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    finish_xfer((adr == `HAD_WB_ADR_HACR) || (adr == `HAD_WB_ADR_DR_HI), unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
    @(posedge cpuclk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    finish_xfer(1'b0, dat);
  endtask

  task automatic push_trace(input logic [63:0] pc);
    @(posedge cpuclk);
    trace_valid <= 1'b1;
    trace_pc    <= pc;
    @(posedge cpuclk);
    trace_valid <= 1'b0;
    // Full FIFO drops the push
    if (m_fifo.size() < `HAD_PCFIFO_DEPTH) m_fifo.push_back(pc);
  endtask

  task automatic hacr_write(input logic [15:0] val);
    logic [31:0]       rd;
    had_pkg::reg_sel_e sel;
    wb_write(`HAD_WB_ADR_HACR, {16'h0, val});
    if (!dbg_disable) begin
      m_hacr = val;
      sel = ref_decode(m_hacr);
      if (m_hacr[`HAD_HACR_RW] && (sel == had_pkg::REG_PCFIFO) && core_match(m_hacr)) begin
        m_regs[had_pkg::REG_PCFIFO] = (m_fifo.size() > 0) ? m_fifo.pop_front() : 64'h0;
      end
    end
    check_sel(had_top_inst.reg_sel, ref_decode(m_hacr));
    check_bit("core_go", core_go, m_hacr[`HAD_HACR_GO] && core_match(m_hacr));
    check_bit("core_ex", core_ex, m_hacr[`HAD_HACR_EX] && core_match(m_hacr));
    check_bit("exit_dbg_reg", exit_dbg_reg, exit_expected(m_hacr));
    check_bit("had_clk_en", had_clk_en, 1'b0);
    wb_read(`HAD_WB_ADR_HACR, rd);
    check_hacr("hacr", rd[15:0], m_hacr);
  endtask

  task automatic dr_write(input logic [31:0] lo, input logic [31:0] hi);
    wb_write(`HAD_WB_ADR_DR_LO, lo);
    wb_write(`HAD_WB_ADR_DR_HI, hi);
    if (!dbg_disable && !m_hacr[`HAD_HACR_RW] && core_match(m_hacr)) begin
      case (ref_decode(m_hacr))
        had_pkg::REG_HCR, had_pkg::REG_WBBR, had_pkg::REG_PC, had_pkg::REG_IR,
        had_pkg::REG_CSR, had_pkg::REG_DADDR, had_pkg::REG_DDATA:
          m_regs[ref_decode(m_hacr)] = {hi, lo};
        default: ;
      endcase
    end
  endtask

  task automatic dr_read();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] exp;
    wb_read(`HAD_WB_ADR_DR_LO, lo);
    wb_read(`HAD_WB_ADR_DR_HI, hi);
    exp = m_regs[ref_decode(m_hacr)];
    check_word("dr_lo", lo, exp[31:0]);
    check_word("dr_hi", hi, exp[63:32]);
  endtask

  task automatic status_check();
    logic [31:0] rd;
    logic        full_e;
    logic        empty_e;
    wb_read(`HAD_WB_ADR_STATUS, rd);
    full_e  = (m_fifo.size() == `HAD_PCFIFO_DEPTH);
    empty_e = (m_fifo.size() == 0);
    check_word("status", rd, {30'h0, full_e, empty_e});
  endtask

  // Write a random DR through one core field and read it back through this core
  task automatic write_then_read(input logic [2:0] bank, input logic [4:0] idx,
                                 input logic [1:0] core);
    logic [31:0] lo;
    logic [31:0] hi;
    hacr_write(make_hacr(1'b0, 1'b0, 1'b0, bank, idx, core));
    lo = rand_bits(32);
    hi = rand_bits(32);
    dr_write(lo, hi);
    hacr_write(make_hacr(1'b1, 1'b0, 1'b0, bank, idx, core_id));
    dr_read();
  endtask

  //============================================================
  // Stimulus
  //============================================================
  initial begin
    logic [31:0] rd;
    logic [31:0] pc_lo;
    logic [31:0] pc_hi;
    int          i;
    wb_cyc      <= 1'b0;
    wb_stb      <= 1'b0;
    wb_we       <= 1'b0;
    wb_adr      <= 2'd0;
    wb_dat_w    <= 32'h0;
    core_id     <= 2'd2;
    dbg_disable <= 1'b0;
    trace_valid <= 1'b0;
    trace_pc    <= 64'h0;
    errors = 0;
    checks = 0;
    lfsr   = 32'ha629_cf42;
    m_hacr = `HAD_HACR_RESET;
    m_regs = '{default: 64'h0};
    m_regs[had_pkg::REG_ID] = `HAD_ID_VALUE;
    @(posedge cpurst_b);
    @(posedge cpuclk);

    // Reset state selects ID for read
    wb_read(`HAD_WB_ADR_HACR, rd);
    check_hacr("hacr", rd[15:0], `HAD_HACR_RESET);
    dr_read();

    // Writable registers and then read only and unmapped selects
    for (i = 0; i < 7; i++) write_then_read(`HAD_BANK0, wr_idx[i], core_id);
    write_then_read(`HAD_BANK0, `HAD_IDX_ID, core_id);
    write_then_read(`HAD_BANK0, `HAD_IDX_HSR, core_id);
    write_then_read(`HAD_BANK0, `HAD_IDX_BYPASS, core_id);
    write_then_read(`HAD_BANK0, 5'd7, core_id);
    write_then_read(`HAD_BANK1, `HAD_IDX_HCR, core_id);
    write_then_read(`HAD_BANK2, `HAD_IDX_PC, core_id);

    // Other core addressed
    for (i = 0; i < 7; i++) write_then_read(`HAD_BANK0, wr_idx[i], core_id ^ 2'd1);
    hacr_write(make_hacr(1'b0, 1'b1, 1'b1, `HAD_BANK0, `HAD_IDX_PC, core_id ^ 2'd1));

    // Trace FIFO with two pushes that overflow
    status_check();
    for (i = 0; i < 10; i++) begin
      pc_hi = rand_bits(32);
      pc_lo = rand_bits(32);
      push_trace({pc_hi, pc_lo});
    end
    status_check();
    for (i = 0; i < 10; i++) begin
      if (i == 3) begin
        hacr_write(make_hacr(1'b1, 1'b0, 1'b0, `HAD_BANK0, `HAD_IDX_PCFIFO, core_id ^ 2'd1));
        dr_read();
      end
      hacr_write(make_hacr(1'b1, 1'b0, 1'b0, `HAD_BANK0, `HAD_IDX_PCFIFO, core_id));
      dr_read();
      if (i == 4) status_check();
    end
    status_check();

    // Go, exit and exit group
    hacr_write(make_hacr(1'b1, 1'b1, 1'b0, `HAD_BANK0, `HAD_IDX_WBBR, core_id));
    hacr_write(make_hacr(1'b1, 1'b0, 1'b1, `HAD_BANK0, `HAD_IDX_BYPASS, core_id));
    hacr_write(make_hacr(1'b1, 1'b1, 1'b1, `HAD_BANK1, `HAD_IDX_PC, core_id));
    for (i = 0; i < 12; i++) begin
      rd = rand_bits(16);
      hacr_write(rd[15:0]);
    end

    // HACR holds while debug is disabled
    hacr_write(make_hacr(1'b1, 1'b0, 1'b0, `HAD_BANK0, `HAD_IDX_CSR, core_id));
    @(posedge cpuclk);
    dbg_disable <= 1'b1;
    hacr_write(make_hacr(1'b1, 1'b1, 1'b1, `HAD_BANK0, `HAD_IDX_PC, core_id));
    @(posedge cpuclk);
    dbg_disable <= 1'b0;
    hacr_write(make_hacr(1'b1, 1'b1, 1'b0, `HAD_BANK0, `HAD_IDX_IR, core_id));
    dr_read();

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    had_pkg::front_state_e st;
    #(TIMEOUT_NS);
    st = had_top_inst.x_had_wb_front.state;
    $display("Watchdog expired after %0d ns, Wishbone front end stuck in %s",
             TIMEOUT_NS, st.name());
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- all.f
+incdir+src
src/had_pkg.sv
src/sync_level2pulse.sv
src/had_wb_front.sv
src/had_private_ir.sv
src/had_regfile.sv
src/had_pcfifo.sv
src/had_top.sv
testbench/tb_clkgen.sv
testbench/tb_had_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_had_top
	./obj_dir/Vtb_had_top | awk '{ print } /TEST PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
